/* hdl/arm_mem_defines.svh */
`ifndef ARM_MEM_DEFINES_SVH
`define ARM_MEM_DEFINES_SVH

// architectural register count
`define ARM_MEM_NREGS 16

`define ARM_MEM_RAM_WORDS 1024 // data RAM depth in 32-bit words

// upper bound on RAM wait cycles per access
`define ARM_MEM_MAX_WAIT 3

`endif

/* hdl/arm_insn_pkg.sv */
`default_nettype none

package arm_insn_pkg;

	// what kind of memory instruction the stage is looking at
	typedef enum logic [1:0] {
		XFER_NONE,
		XFER_SINGLE,
		XFER_BLOCK,
		XFER_UNDEF
	} xfer_class_t;

	typedef struct packed {
		logic load;       // L bit
		logic byte_sel;   // B bit, single transfers only
		logic up;         // U bit
		logic pre;        // P bit
		logic wback;      // W bit
		logic [3:0] rd;   // dest/source reg of LDR/STR
		logic [3:0] rn;   // base reg
		logic [15:0] reg_list;
	} xfer_fields_t;

endpackage

`default_nettype wire

/* hdl/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_READ,
		BUS_WRITE
	} bus_op_t;

	typedef logic [3:0] byte_en_t; // bit n enables bits 8n+7..8n

endpackage

`default_nettype wire

/* hdl/mem_bus_if.sv */
`default_nettype none

interface mem_bus_if import mem_bus_pkg::*; ();

	logic [31:0] addr; // word aligned
	bus_op_t op;
	byte_en_t byte_en;
	logic [31:0] wr_data;
	logic [31:0] rd_data;
	logic wait_req;

	modport master (
		output addr, op, byte_en, wr_data,
		input rd_data, wait_req
	);

	modport slave (
		input addr, op, byte_en, wr_data,
		output rd_data, wait_req
	);

endinterface

`default_nettype wire

/* hdl/insn_decode.sv */
`default_nettype none

module insn_decode import arm_insn_pkg::*; (
	input wire [31:0] insn,
	output xfer_class_t xclass,
	output xfer_fields_t fields
);

	logic is_single;
	logic is_undef;
	logic is_block;

	assign is_single = insn[27:26] == 2'b01;
	assign is_undef = insn[27:25] == 3'b011 && insn[4]; // reg offset space with bit 4 set
	assign is_block = insn[27:25] == 3'b100;

	always_comb begin
		xclass = XFER_NONE;
		if (is_undef)
			xclass = XFER_UNDEF;
		else if (is_single)
			xclass = XFER_SINGLE;
		else if (is_block)
			xclass = XFER_BLOCK;
	end

	// same bit positions for LDR/STR and LDM/STM
	always_comb begin
		fields.pre = insn[24];
		fields.up = insn[23];
		fields.byte_sel = insn[22]; // S bit on block transfers, ignored there
		fields.wback = insn[21];
		fields.load = insn[20];
		fields.rn = insn[19:16];
		fields.rd = insn[15:12];
		fields.reg_list = insn[15:0];
	end

endmodule

`default_nettype wire

/* hdl/ldm_sequencer.sv */
`default_nettype none

module ldm_sequencer import arm_insn_pkg::*; (
	input wire clk,
	input wire reset,
	input wire start,
	input wire xfer_fields_t fields,
	input wire [31:0] base,
	input wire advance,
	output logic [3:0] cur_reg,
	output logic [31:0] cur_addr,
	output logic last,
	output logic [31:0] wb_addr
);

	logic [15:0] pending;
	logic [31:0] addr_q;
	logic [4:0] count;
	logic [31:0] span;
	logic [31:0] start_addr;

	always_comb begin
		count = '0;
		for (int i = 0; i < 16; i++)
			count = count + 5'(fields.reg_list[i]);
	end

	assign span = {25'b0, count, 2'b00};

	// lowest register always sits at the lowest address
	always_comb begin
		if (fields.up) begin
			start_addr = fields.pre ? base + 32'd4 : base;
			wb_addr = base + span;
		end else begin
			start_addr = fields.pre ? base - span : base - span + 32'd4;
			wb_addr = base - span;
		end
	end

	always_comb begin
		cur_reg = '0;
		for (int i = 15; i >= 0; i--)
			if (pending[i])
				cur_reg = 4'(i);
	end

	assign last = (pending & (pending - 16'd1)) == '0; // one bit left
	assign cur_addr = addr_q;

	always_ff @(posedge clk) begin
		if (reset)
			pending <= '0;
		else if (start)
			pending <= fields.reg_list;
		else if (advance)
			pending[cur_reg] <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (start)
			addr_q <= start_addr;
		else if (advance)
			addr_q <= addr_q + 32'd4;
	end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`default_nettype none

module mem_stage import arm_insn_pkg::*, mem_bus_pkg::*; (
	input wire clk,
	input wire reset,
	mem_bus_if.master bus,
	output logic [3:0] st_read,
	input wire [31:0] st_data,
	input wire in_bubble,
	input wire [31:0] pc,
	input wire [31:0] insn,
	input wire [31:0] op0,
	input wire [31:0] op1,
	input wire [31:0] op2,
	output logic stall,
	output logic out_bubble,
	output logic [31:0] out_pc,
	output logic [31:0] out_insn,
	output logic out_write_reg,
	output logic [3:0] out_write_num,
	output logic [31:0] out_write_data
);

	typedef enum logic [1:0] {ST_IDLE, ST_BLOCK, ST_WB} state_t;

	state_t state, state_nx;
	xfer_class_t xclass;
	xfer_fields_t fields;
	logic [31:0] off_addr, acc_addr;
	logic single_wb;
	logic eff_bubble;
	logic [31:0] rot_half, rot_data, load_data;
	logic seq_start, seq_advance, seq_last;
	logic [3:0] seq_reg;
	logic [31:0] seq_addr, seq_wb;
	logic wr_nx;
	logic [3:0] wr_num_nx;
	logic [31:0] wr_data_nx;

	insn_decode u_decode (.insn(insn), .xclass(xclass), .fields(fields));

	ldm_sequencer u_seq (
		.clk(clk), .reset(reset), .start(seq_start), .fields(fields), .base(op0),
		.advance(seq_advance), .cur_reg(seq_reg), .cur_addr(seq_addr), .last(seq_last),
		.wb_addr(seq_wb)
	);

	assign off_addr = fields.up ? op0 + op1 : op0 - op1;
	assign acc_addr = fields.pre ? off_addr : op0;
	assign single_wb = !fields.pre || fields.wback; // post-index always writes back
	assign eff_bubble = in_bubble || (xclass == XFER_BLOCK && fields.reg_list == '0);
	assign st_read = seq_reg;

	// rotate addressed byte down to lane 0
	assign rot_half = acc_addr[1] ? {bus.rd_data[15:0], bus.rd_data[31:16]} : bus.rd_data;
	assign rot_data = acc_addr[0] ? {rot_half[7:0], rot_half[31:8]} : rot_half;
	assign load_data = fields.byte_sel ? {24'b0, rot_data[7:0]} : rot_data;

	// bus side
	always_comb begin
		bus.op = BUS_IDLE;
		if (state == ST_BLOCK || (state == ST_IDLE && !in_bubble && xclass == XFER_SINGLE))
			bus.op = fields.load ? BUS_READ : BUS_WRITE;
		if (state == ST_BLOCK) begin
			bus.addr = {seq_addr[31:2], 2'b00};
			bus.wr_data = st_data;
			bus.byte_en = 4'hf;
		end else if (fields.byte_sel) begin
			bus.addr = {acc_addr[31:2], 2'b00};
			bus.wr_data = {4{op2[7:0]}};
			bus.byte_en = 4'b0001 << acc_addr[1:0]; // one lane only
		end else begin
			bus.addr = {acc_addr[31:2], 2'b00};
			bus.wr_data = op2;
			bus.byte_en = 4'hf;
		end
	end

	// sequencing and result selection
	always_comb begin
		state_nx = state;
		stall = 1'b0;
		seq_start = 1'b0;
		seq_advance = 1'b0;
		wr_nx = 1'b0;
		wr_num_nx = fields.rd;
		wr_data_nx = load_data;
		case (state)
			ST_IDLE: if (!in_bubble) begin
				if (xclass == XFER_SINGLE) begin
					if (bus.wait_req) begin
						stall = 1'b1;
					end else if (fields.load) begin
						wr_nx = 1'b1;
						if (single_wb) begin
							stall = 1'b1; // base write next cycle
							state_nx = ST_WB;
						end
					end else if (single_wb) begin
						wr_nx = 1'b1;
						wr_num_nx = fields.rn;
						wr_data_nx = off_addr;
					end
				end else if (xclass == XFER_BLOCK && fields.reg_list != '0) begin
					seq_start = 1'b1;
					stall = 1'b1;
					state_nx = ST_BLOCK;
				end
			end
			ST_BLOCK: begin
				stall = 1'b1;
				if (!bus.wait_req) begin
					seq_advance = 1'b1;
					if (fields.load) begin
						wr_nx = 1'b1;
						wr_num_nx = seq_reg;
						wr_data_nx = bus.rd_data;
					end
					if (seq_last) begin
						if (fields.wback && fields.load) begin
							state_nx = ST_WB;
						end else begin
							stall = 1'b0;
							state_nx = ST_IDLE;
							if (fields.wback) begin
								wr_nx = 1'b1;
								wr_num_nx = fields.rn;
								wr_data_nx = seq_wb;
							end
						end
					end
				end
			end
			ST_WB: begin
				wr_nx = 1'b1;
				wr_num_nx = fields.rn;
				wr_data_nx = (xclass == XFER_BLOCK) ? seq_wb : off_addr;
				state_nx = ST_IDLE;
			end
			default: state_nx = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			out_bubble <= 1'b1;
			out_write_reg <= 1'b0;
		end else begin
			state <= state_nx;
			out_bubble <= !(wr_nx || (!eff_bubble && !stall));
			out_write_reg <= wr_nx;
		end
	end

	always_ff @(posedge clk) begin
		out_pc <= pc;
		out_insn <= insn;
		out_write_num <= wr_num_nx;
		out_write_data <= wr_data_nx;
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

`include "arm_mem_defines.svh"

module reg_file (
	input wire clk,
	input wire reset,
	input wire [3:0] st_read,
	output logic [31:0] st_data,
	input wire write_reg,
	input wire [3:0] write_num,
	input wire [31:0] write_data
);

	logic [31:0] regs [`ARM_MEM_NREGS];

	assign st_data = regs[st_read]; // no bypass, write shows next cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ARM_MEM_NREGS; i++)
				regs[i] <= '0;
		end else if (write_reg) begin
			regs[write_num] <= write_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/data_ram.sv */
`default_nettype none

`include "arm_mem_defines.svh"

module data_ram import mem_bus_pkg::*; (
	input wire clk,
	input wire reset,
	mem_bus_if.slave bus
);

	localparam int IDX_W = $clog2(`ARM_MEM_RAM_WORDS);
	localparam int WAIT_W = $clog2(`ARM_MEM_MAX_WAIT + 1);

	logic [31:0] mem [`ARM_MEM_RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [15:0] lfsr;
	logic busy; // access already counting down
	logic [WAIT_W-1:0] cnt, pick, remaining;
	logic active, complete;

	initial begin
		for (int i = 0; i < `ARM_MEM_RAM_WORDS; i++)
			mem[i] = '0;
	end

	assign idx = bus.addr[IDX_W+1:2];
	assign active = bus.op != BUS_IDLE;
	assign pick = WAIT_W'(lfsr % (`ARM_MEM_MAX_WAIT + 1));
	assign remaining = busy ? cnt : pick;
	assign bus.wait_req = active && remaining != '0;
	assign complete = active && remaining == '0;
	assign bus.rd_data = mem[idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= 16'hace1;
			busy <= 1'b0;
			cnt <= '0;
		end else begin
			if (active && !busy) // new access, draw next wait count
				lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			if (bus.wait_req) begin
				busy <= 1'b1;
				cnt <= remaining - 1'b1;
			end else begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (complete && bus.op == BUS_WRITE) begin
			for (int b = 0; b < 4; b++)
				if (bus.byte_en[b])
					mem[idx][8*b +: 8] <= bus.wr_data[8*b +: 8];
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_subsystem.sv */
`default_nettype none

module mem_subsystem (
	input wire clk,
	input wire reset,
	input wire in_bubble,
	input wire [31:0] pc,
	input wire [31:0] insn,
	input wire [31:0] op0,
	input wire [31:0] op1,
	input wire [31:0] op2,
	output wire stall,
	output wire out_bubble,
	output wire [31:0] out_pc,
	output wire [31:0] out_insn,
	output wire out_write_reg,
	output wire [3:0] out_write_num,
	output wire [31:0] out_write_data
);

	wire [3:0] st_read;
	wire [31:0] st_data;

	mem_bus_if bus ();

	mem_stage u_stage (
		.clk(clk), .reset(reset), .bus(bus.master),
		.st_read(st_read), .st_data(st_data),
		.in_bubble(in_bubble), .pc(pc), .insn(insn), .op0(op0), .op1(op1), .op2(op2),
		.stall(stall), .out_bubble(out_bubble), .out_pc(out_pc), .out_insn(out_insn),
		.out_write_reg(out_write_reg), .out_write_num(out_write_num),
		.out_write_data(out_write_data)
	);

	// writeback straight from the stage output register
	reg_file u_regs (
		.clk(clk), .reset(reset), .st_read(st_read), .st_data(st_data),
		.write_reg(out_write_reg), .write_num(out_write_num), .write_data(out_write_data)
	);

	data_ram u_ram (.clk(clk), .reset(reset), .bus(bus.slave));

endmodule

`default_nettype wire

/* sim/mem_checker.sv */
`default_nettype none

`include "arm_mem_defines.svh"

module mem_checker (
	input wire clk,
	input wire reset,
	input wire in_bubble,
	input wire [31:0] pc,
	input wire [31:0] insn,
	input wire [31:0] op0,
	input wire [31:0] op1,
	input wire [31:0] op2,
	input wire stall,
	input wire out_bubble,
	input wire [31:0] out_pc,
	input wire [31:0] out_insn,
	input wire out_write_reg,
	input wire [3:0] out_write_num,
	input wire [31:0] out_write_data,
	input wire final_check,
	output logic report_done,
	output int mismatches,
	output int missing,
	output int surplus,
	output int other_errors
);

	localparam int IDX_W = $clog2(`ARM_MEM_RAM_WORDS);

	logic [31:0] regs [`ARM_MEM_NREGS];
	logic [31:0] mem [`ARM_MEM_RAM_WORDS];
	logic [35:0] exp_q [$]; // {reg, data}
	logic [35:0] act_q [$];
	logic reset_seen;
	int n_writes;
	logic prev_taken; // previous cycle handed a result to the output register
	logic prev_empty;
	logic [31:0] prev_pc, prev_insn;

	initial begin
		for (int i = 0; i < `ARM_MEM_NREGS; i++)
			regs[i] = '0;
		for (int i = 0; i < `ARM_MEM_RAM_WORDS; i++)
			mem[i] = '0;
		reset_seen = 1'b0;
		n_writes = 0;
		report_done = 1'b0;
		mismatches = 0;
		missing = 0;
		surplus = 0;
		other_errors = 0;
		prev_taken = 1'b0;
		prev_empty = 1'b0;
		prev_pc = '0;
		prev_insn = '0;
	end

	function automatic void expect_write(input logic [3:0] num, input logic [31:0] data);
		exp_q.push_back({num, data});
		regs[num] = data;
	endfunction

	// ARM LDR/STR/LDM/STM rules applied to the shadow state
	function automatic void predict(input logic [31:0] word, input logic [31:0] base,
			input logic [31:0] offset, input logic [31:0] sdata);
		logic [31:0] off_addr, addr, data;
		logic [63:0] twice;
		logic [IDX_W-1:0] idx;
		int n;
		off_addr = word[23] ? base + offset : base - offset;
		addr = word[24] ? off_addr : base;
		idx = addr[IDX_W+1:2];
		if (word[27:26] == 2'b01 && !(word[25] && word[4])) begin
			if (word[20]) begin
				twice = {mem[idx], mem[idx]} >> (8 * addr[1:0]); // rotate right by lane
				data = word[22] ? {24'b0, twice[7:0]} : twice[31:0];
				expect_write(word[15:12], data);
			end else if (word[22]) begin
				mem[idx][8 * addr[1:0] +: 8] = sdata[7:0];
			end else begin
				mem[idx] = sdata;
			end
			if (!word[24] || word[21])
				expect_write(word[19:16], off_addr);
		end else if (word[27:25] == 3'b100 && word[15:0] != '0) begin
			n = $countones(word[15:0]);
			if (word[23])
				addr = word[24] ? base + 32'd4 : base;
			else
				addr = word[24] ? base - 32'(4 * n) : base - 32'(4 * n) + 32'd4;
			for (int i = 0; i < 16; i++) begin
				if (word[i]) begin
					idx = addr[IDX_W+1:2];
					if (word[20])
						expect_write(4'(i), mem[idx]);
					else
						mem[idx] = regs[i];
					addr = addr + 32'd4;
				end
			end
			if (word[21])
				expect_write(word[19:16], word[23] ? base + 32'(4 * n) : base - 32'(4 * n));
		end
	endfunction

	always @(posedge clk)
		reset_seen <= reset;

	always @(negedge clk) begin : compare
		logic [35:0] e, a;
		logic empty_blk;
		empty_blk = insn[27:25] == 3'b100 && insn[15:0] == '0;
		if (reset_seen && (!out_bubble || out_write_reg || (in_bubble && stall))) begin
			$display("reset state wrong at %0t: outputs not idle after reset", $time);
			other_errors++;
		end
		if (!reset) begin
			if (out_write_reg && out_bubble) begin
				$display("mismatch at %0t: register write while out_bubble is high", $time);
				mismatches++;
			end
			if (prev_taken && out_bubble) begin
				$display("mismatch at %0t: out_bubble high after an accepted instruction",
					$time);
				mismatches++;
			end
			if (prev_empty && !out_bubble) begin
				$display("mismatch at %0t: out_bubble low after an empty slot", $time);
				mismatches++;
			end
			if (!out_bubble && (out_pc != prev_pc || out_insn != prev_insn)) begin
				$display("mismatch at %0t: out_pc/out_insn %08h/%08h, expected %08h/%08h",
					$time, out_pc, out_insn, prev_pc, prev_insn);
				mismatches++;
			end
			if (!in_bubble && !stall)
				predict(insn, op0, op1, op2); // instruction accepted this cycle
			if (out_write_reg)
				act_q.push_back({out_write_num, out_write_data});
		end
		prev_taken = !reset && !in_bubble && !stall && !empty_blk;
		prev_empty = !reset && (in_bubble || empty_blk);
		prev_pc = pc;
		prev_insn = insn;
		while (exp_q.size() > 0 && act_q.size() > 0) begin
			e = exp_q.pop_front();
			a = act_q.pop_front();
			n_writes++;
			if (a != e) begin
				$display("mismatch at %0t: write %0d expected r%0d = %08h, got r%0d = %08h",
					$time, n_writes, e[35:32], e[31:0], a[35:32], a[31:0]);
				mismatches++;
			end
		end
		if (final_check && !report_done) begin
			while (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				$display("missing write: r%0d = %08h never came out", e[35:32], e[31:0]);
				missing++;
			end
			while (act_q.size() > 0) begin
				a = act_q.pop_front();
				$display("surplus write: r%0d = %08h had no instruction behind it",
					a[35:32], a[31:0]);
				surplus++;
			end
			report_done = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* sim/tb_mem_subsystem.sv */
`default_nettype none

`include "arm_mem_defines.svh"

module tb_mem_subsystem;

	localparam int ROUNDS = 40;
	localparam int TEST_COUNT = 2 * `ARM_MEM_NREGS + ROUNDS * 12;
	localparam int TIMEOUT_CYCLES =
		TEST_COUNT * (`ARM_MEM_NREGS + 2) * (`ARM_MEM_MAX_WAIT + 2) + 200;

	logic clk;
	logic reset;
	logic in_bubble;
	logic [31:0] pc, insn, op0, op1, op2;
	wire stall, out_bubble, out_write_reg;
	wire [31:0] out_pc, out_insn, out_write_data;
	wire [3:0] out_write_num;
	logic final_check;
	wire report_done;
	int mismatches, missing, surplus, other_errors;
	integer seed = 32'h745f_d62d;
	int cycles;

	mem_subsystem i_mem_subsystem (
		.clk(clk), .reset(reset), .in_bubble(in_bubble), .pc(pc), .insn(insn),
		.op0(op0), .op1(op1), .op2(op2), .stall(stall), .out_bubble(out_bubble),
		.out_pc(out_pc), .out_insn(out_insn), .out_write_reg(out_write_reg),
		.out_write_num(out_write_num), .out_write_data(out_write_data)
	);

	mem_checker u_check (
		.clk(clk), .reset(reset), .in_bubble(in_bubble), .pc(pc), .insn(insn),
		.op0(op0), .op1(op1), .op2(op2), .stall(stall), .out_bubble(out_bubble),
		.out_pc(out_pc), .out_insn(out_insn),
		.out_write_reg(out_write_reg), .out_write_num(out_write_num),
		.out_write_data(out_write_data), .final_check(final_check),
		.report_done(report_done), .mismatches(mismatches), .missing(missing),
		.surplus(surplus), .other_errors(other_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: DUT hang, run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [31:0] make_single(input logic l, input logic b, input logic u,
			input logic p, input logic w, input logic [3:0] rn, input logic [3:0] rd);
		return {4'he, 3'b010, p, u, b, w, l, rn, rd, 12'h000}; // offset comes from op1
	endfunction

	function automatic logic [31:0] make_block(input logic l, input logic u, input logic p,
			input logic w, input logic [3:0] rn, input logic [15:0] list);
		return {4'he, 3'b100, p, u, 1'b0, w, l, rn, list};
	endfunction

	// nonzero list that leaves out the base
	function automatic logic [15:0] pick_list(input logic [15:0] raw, input logic [3:0] rn);
		logic [15:0] list;
		list = raw & ~(16'd1 << rn);
		if (list == '0)
			list = 16'd1 << (rn + 4'd1);
		return list;
	endfunction

	function automatic logic [31:0] no_transfer(input logic [31:0] r);
		case (r[1:0])
			2'd0: return 32'he081_0002; // add r0, r1, r2
			2'd1: return 32'he610_0010 | (r & 32'h00ff_ff00); // undefined space
			2'd2: return 32'hea00_0000 | (r & 32'h00ff_ffff); // branch
			default: return make_block(r[20], r[23], r[24], r[21], r[19:16], 16'h0);
		endcase
	endfunction

	task automatic gap();
		logic [31:0] r;
		r = next_random();
		if (r[1:0] != 2'd0) begin
			in_bubble <= 1'b1;
			insn <= make_single(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, r[19:16], r[15:12]);
			op0 <= r;
			repeat (r[1:0]) @(posedge clk);
		end
	endtask

	// present one instruction and hold it until stall drops
	task automatic issue(input logic [31:0] word, input logic [31:0] base,
			input logic [31:0] offset, input logic [31:0] data);
		logic done;
		in_bubble <= 1'b0;
		insn <= word;
		op0 <= base;
		op1 <= offset;
		op2 <= data;
		pc <= pc + 32'd4;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = !stall;
			@(posedge clk);
		end
		gap();
	endtask

	task automatic run_round();
		logic [31:0] r, s, base;
		logic [15:0] list;
		r = next_random();
		s = next_random();
		base = 32'h400 + (r & 32'h3fc);
		issue(make_single(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, r[19:16], r[15:12]),
			base, s & 32'hfc, next_random());
		issue(make_single(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, r[19:16], r[23:20]),
			base, s & 32'hfc, 32'h0);
		// one lane written, then all four read back
		issue(make_single(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, r[19:16], r[15:12]),
			base, {30'b0, s[9:8]}, next_random());
		for (int j = 0; j < 4; j++)
			issue(make_single(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, r[19:16], r[27:24] + 4'(j)),
				base, 32'(j), 32'h0);
		issue(make_single(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, r[19:16], r[31:28]),
			base + 32'd4, {30'b0, s[11:10] | 2'b01}, 32'h0); // unaligned word
		r = next_random();
		s = next_random();
		issue(make_single(r[0], r[1], r[2], r[3], r[4], r[11:8], r[15:12]),
			32'h400 + (s & 32'h3ff), {24'b0, s[31:24]}, next_random());
		// STM then LDM over the same words
		r = next_random();
		s = next_random();
		base = 32'h800 + (s & 32'h1fc);
		list = pick_list(r[31:16], r[11:8]);
		issue(make_block(1'b0, r[0], r[1], r[2], r[11:8], list), base, 32'h0, 32'h0);
		list = pick_list(s[31:16], r[11:8]);
		issue(make_block(1'b1, r[0], r[1], r[3], r[11:8], list), base, 32'h0, 32'h0);
		r = next_random();
		issue(no_transfer(r), r, next_random(), next_random());
	endtask

	initial begin
		logic [31:0] v;
		reset = 1'b1;
		in_bubble = 1'b1;
		pc = '0;
		insn = '0;
		op0 = '0;
		op1 = '0;
		op2 = '0;
		final_check = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// every register gets a random word through memory
		for (int i = 0; i < `ARM_MEM_NREGS; i++) begin
			v = next_random();
			issue(make_single(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd0, 4'(i)), 32'h0, 32'(4 * i), v);
			issue(make_single(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 4'd0, 4'(i)), 32'h0, 32'(4 * i),
				32'h0);
		end
		repeat (ROUNDS) run_round();
		in_bubble <= 1'b1;
		repeat (4) @(posedge clk); // last writes drain
		final_check <= 1'b1;
		while (!report_done)
			@(posedge clk);
		$display("errors: %0d mismatch, %0d missing, %0d surplus, %0d other",
			mismatches, missing, surplus, other_errors);
		if (mismatches + missing + surplus + other_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* mem_subsystem.f */
+incdir+hdl
hdl/arm_insn_pkg.sv
hdl/mem_bus_pkg.sv
hdl/mem_bus_if.sv
hdl/insn_decode.sv
hdl/ldm_sequencer.sv
hdl/mem_stage.sv
hdl/reg_file.sv
hdl/data_ram.sv
hdl/mem_subsystem.sv
sim/mem_checker.sv
sim/tb_mem_subsystem.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_mem_subsystem
FILELIST = mem_subsystem.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
